// ==== src/sprite_consts.svh ====
`ifndef SPRITE_CONSTS_SVH
`define SPRITE_CONSTS_SVH

// byte address of framebuffer pixel (0,0)
`define SPRITE_FB_BASE 32'h0001_0000

// row pitch in pixels
`define SPRITE_FB_WIDTH 64

// coordinates, sizes and scales
`define SPRITE_COORD_W 16

// bus address and data width
`define SPRITE_ADDR_W 32

`endif

// ==== src/sprite_pkg.sv ====
`include "sprite_consts.svh"

package sprite_pkg;

    typedef struct packed {
        logic [`SPRITE_ADDR_W-1:0]         sheet_base;
        logic [`SPRITE_COORD_W-1:0]        sheet_width; // pixels per sheet row
        logic [`SPRITE_COORD_W-1:0]        src_x;
        logic [`SPRITE_COORD_W-1:0]        src_y;
        logic [`SPRITE_COORD_W-1:0]        dst_x;
        logic [`SPRITE_COORD_W-1:0]        dst_y;
        logic [`SPRITE_COORD_W-1:0]        width;       // screen pixels
        logic [`SPRITE_COORD_W-1:0]        height;
        logic signed [`SPRITE_COORD_W-1:0] scale_x;     // <0 downscale
        logic signed [`SPRITE_COORD_W-1:0] scale_y;
        logic                              mirror_x;
        logic                              mirror_y;
    } blit_cmd_t;

    typedef struct packed {
        logic [31:0]                sheet_x;     // wide on purpose
        logic [31:0]                sheet_y;
        logic [`SPRITE_COORD_W-1:0] screen_x;
        logic [`SPRITE_COORD_W-1:0] screen_y;
        logic                       last;
    } frag_t;

    typedef struct packed {
        logic [`SPRITE_ADDR_W-1:0]  sheet_addr;  // byte address of pixel
        logic [`SPRITE_COORD_W-1:0] screen_x;
        logic [`SPRITE_COORD_W-1:0] screen_y;
        logic                       last;
    } fetch_req_t;

    typedef struct packed {
        logic [15:0]                color;
        logic [`SPRITE_COORD_W-1:0] screen_x;
        logic [`SPRITE_COORD_W-1:0] screen_y;
        logic                       last;
    } pixel_t;

endpackage

// ==== src/pipe_skid.sv ====
`timescale 1ns/1ps

module pipe_skid #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    payload_t main_q;
    payload_t skid_q;
    logic     main_v;
    logic     skid_v;

    assign in_ready  = !skid_v; // registered, breaks the ready path
    assign out_valid = main_v;
    assign out_data  = main_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            main_v <= 1'b0;
            skid_v <= 1'b0;
        end else if (!main_v || out_ready) begin
            if (skid_v) begin
                main_q <= skid_q; // drain overflow first
                main_v <= 1'b1;
                skid_v <= 1'b0;
            end else begin
                main_q <= in_data;
                main_v <= in_valid;
            end
        end else if (in_valid && in_ready) begin
            skid_q <= in_data; // output stalled, park it
            skid_v <= 1'b1;
        end
    end

endmodule

// ==== src/sprite_coord_gen.sv ====
`timescale 1ns/1ps
`include "sprite_consts.svh"

module sprite_coord_gen (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  sprite_pkg::blit_cmd_t cmd,
    input  logic                  frame_done,
    output logic                  frag_valid,
    input  logic                  frag_ready,
    output sprite_pkg::frag_t     frag,
    output sprite_pkg::blit_cmd_t cmd_q
);

    typedef enum logic [1:0] {
        C_IDLE,
        C_GEN,
        C_WAIT
    } state_t;

    state_t                     state;
    sprite_pkg::blit_cmd_t      cmd_r;
    logic [`SPRITE_COORD_W-1:0] i, j;
    logic [`SPRITE_COORD_W-1:0] sub_x, sub_y;
    logic [31:0]                ss_x, ss_y;
    logic [`SPRITE_COORD_W-1:0] mag_x, mag_y;
    logic [`SPRITE_COORD_W-1:0] last_i, last_j;
    logic                       down_x, down_y;
    logic                       accept, step;

    // magnitude of a signed scale, 0 counts as 1
    function automatic logic [`SPRITE_COORD_W-1:0] scale_mag(input logic [`SPRITE_COORD_W-1:0] s);
        logic [`SPRITE_COORD_W-1:0] m;
        m = s[`SPRITE_COORD_W-1] ? -s : s;
        return (m == '0) ? `SPRITE_COORD_W'(1) : m;
    endfunction

    assign accept     = cmd_valid && cmd_ready;
    assign step       = frag_valid && frag_ready;
    assign frag_valid = (state == C_GEN);
    assign cmd_q      = cmd_r;
    assign mag_x      = scale_mag(cmd_r.scale_x);
    assign mag_y      = scale_mag(cmd_r.scale_y);
    assign down_x     = cmd_r.scale_x[`SPRITE_COORD_W-1];
    assign down_y     = cmd_r.scale_y[`SPRITE_COORD_W-1];
    assign last_i     = cmd_r.width - 1'b1;
    assign last_j     = cmd_r.height - 1'b1;

    always_comb begin
        frag.sheet_x  = ss_x;
        frag.sheet_y  = ss_y;
        frag.screen_x = cmd_r.mirror_x ? cmd_r.dst_x + last_i - i : cmd_r.dst_x + i;
        frag.screen_y = cmd_r.mirror_y ? cmd_r.dst_y + last_j - j : cmd_r.dst_y + j;
        frag.last     = (i == last_i) && (j == last_j);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= C_IDLE;
            cmd_ready <= 1'b0;
        end else begin
            if (accept) begin
                cmd_ready <= 1'b0;
            end else if (state == C_IDLE || frame_done) begin
                cmd_ready <= 1'b1;
            end
            if (accept) begin
                cmd_r <= cmd;
                i     <= '0;
                j     <= '0;
                sub_x <= '0;
                sub_y <= '0;
                ss_x  <= {16'b0, cmd.src_x};
                ss_y  <= {16'b0, cmd.src_y};
                state <= C_GEN;
            end else if (step && i == last_i) begin
                i     <= '0; // next row, x restarts
                j     <= j + 1'b1;
                sub_x <= '0;
                ss_x  <= {16'b0, cmd_r.src_x};
                if (down_y) begin
                    ss_y <= ss_y + mag_y;
                end else if (sub_y == mag_y - 1'b1) begin
                    sub_y <= '0;
                    ss_y  <= ss_y + 1'b1;
                end else begin
                    sub_y <= sub_y + 1'b1;
                end
                if (j == last_j) state <= C_WAIT;
            end else if (step) begin
                i <= i + 1'b1;
                if (down_x) begin
                    ss_x <= ss_x + mag_x;
                end else if (sub_x == mag_x - 1'b1) begin
                    sub_x <= '0;
                    ss_x  <= ss_x + 1'b1;
                end else begin
                    sub_x <= sub_x + 1'b1;
                end
            end else if (state == C_WAIT && frame_done) begin
                state <= C_IDLE;
            end
        end
    end

endmodule

// ==== src/sprite_addr_calc.sv ====
`timescale 1ns/1ps
`include "sprite_consts.svh"

module sprite_addr_calc (
    input  logic                   clk,
    input  logic                   rst,
    input  sprite_pkg::blit_cmd_t  cmd_q,
    input  logic                   frag_valid,
    output logic                   frag_ready,
    input  sprite_pkg::frag_t      frag,
    output logic                   req_valid,
    input  logic                   req_ready,
    output sprite_pkg::fetch_req_t req
);

    logic [`SPRITE_ADDR_W-1:0] pix_index;
    sprite_pkg::fetch_req_t    req_in;

    // pixel index within the sheet, 16-bit pixels
    assign pix_index = frag.sheet_y * {16'b0, cmd_q.sheet_width} + frag.sheet_x;

    always_comb begin
        req_in.sheet_addr = cmd_q.sheet_base + (pix_index << 1);
        req_in.screen_x   = frag.screen_x;
        req_in.screen_y   = frag.screen_y;
        req_in.last       = frag.last;
    end

    pipe_skid #(
        .payload_t (sprite_pkg::fetch_req_t)
    ) skid_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (frag_valid),
        .in_ready  (frag_ready),
        .in_data   (req_in),
        .out_valid (req_valid),
        .out_ready (req_ready),
        .out_data  (req)
    );

endmodule

// ==== src/sprite_pixel_fetch.sv ====
`timescale 1ns/1ps
`include "sprite_consts.svh"

module sprite_pixel_fetch (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  sprite_pkg::fetch_req_t    req,
    output logic                      arvalid,
    input  logic                      arready,
    output logic [`SPRITE_ADDR_W-1:0] araddr,
    input  logic                      rvalid,
    output logic                      rready,
    input  logic [`SPRITE_ADDR_W-1:0] rdata,
    output logic                      pix_valid,
    input  logic                      pix_ready,
    output sprite_pkg::pixel_t        pix
);

    typedef enum logic [1:0] {
        F_IDLE,
        F_ADDR,
        F_DATA,
        F_OUT
    } state_t;

    state_t                    state;
    sprite_pkg::fetch_req_t    req_q;
    sprite_pkg::pixel_t        pix_in;
    logic [`SPRITE_ADDR_W-1:0] cache_data;
    logic [`SPRITE_ADDR_W-3:0] cache_tag;  // word address
    logic                      cache_valid;
    logic                      hit, r_hs, out_valid_in, out_ready_in;
    logic [`SPRITE_ADDR_W-1:0] word;
    sprite_pkg::fetch_req_t    cur;

    assign hit       = cache_valid && (cache_tag == req.sheet_addr[`SPRITE_ADDR_W-1:2]);
    assign r_hs      = rvalid && rready;
    assign req_ready = (state == F_IDLE) && out_ready_in;

    always_comb begin
        cur          = (state == F_IDLE) ? req : req_q;
        word         = (state == F_DATA) ? rdata : cache_data; // bypass on refill
        pix_in.color    = cur.sheet_addr[1] ? word[31:16] : word[15:0];
        pix_in.screen_x = cur.screen_x;
        pix_in.screen_y = cur.screen_y;
        pix_in.last     = cur.last;
        case (state)
            F_IDLE:  out_valid_in = req_valid && hit;
            F_DATA:  out_valid_in = r_hs;
            F_OUT:   out_valid_in = 1'b1;
            default: out_valid_in = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= F_IDLE;
            arvalid     <= 1'b0;
            rready      <= 1'b0;
            cache_valid <= 1'b0;
        end else begin
            case (state)
                F_IDLE: if (req_valid && req_ready && !hit) begin
                    req_q   <= req;
                    araddr  <= {req.sheet_addr[`SPRITE_ADDR_W-1:2], 2'b00};
                    arvalid <= 1'b1;
                    state   <= F_ADDR;
                end
                F_ADDR: if (arready) begin
                    arvalid <= 1'b0;
                    rready  <= 1'b1;
                    state   <= F_DATA;
                end
                F_DATA: if (r_hs) begin
                    rready      <= 1'b0;
                    cache_valid <= 1'b1;
                    cache_tag   <= req_q.sheet_addr[`SPRITE_ADDR_W-1:2];
                    cache_data  <= rdata;
                    state       <= out_ready_in ? F_IDLE : F_OUT;
                end
                F_OUT: if (out_ready_in) state <= F_IDLE;
                default: state <= F_IDLE;
            endcase
        end
    end

    pipe_skid #(
        .payload_t (sprite_pkg::pixel_t)
    ) skid_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (out_valid_in),
        .in_ready  (out_ready_in),
        .in_data   (pix_in),
        .out_valid (pix_valid),
        .out_ready (pix_ready),
        .out_data  (pix)
    );

endmodule

// ==== src/sprite_pixel_write.sv ====
`timescale 1ns/1ps
`include "sprite_consts.svh"

module sprite_pixel_write (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pix_valid,
    output logic                      pix_ready,
    input  sprite_pkg::pixel_t        pix,
    output logic                      awvalid,
    input  logic                      awready,
    output logic [`SPRITE_ADDR_W-1:0] awaddr,
    output logic                      wvalid,
    input  logic                      wready,
    output logic [`SPRITE_ADDR_W-1:0] wdata,
    output logic [3:0]                wstrb,
    input  logic                      bvalid,
    output logic                      bready,
    output logic                      frame_done
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_SEND,
        W_RESP
    } state_t;

    state_t                    state;
    logic [`SPRITE_ADDR_W-1:0] fb_index;
    logic [`SPRITE_ADDR_W-1:0] fb_addr;
    logic                      last_q;
    logic                      aw_done, w_done;

    assign fb_index   = {16'b0, pix.screen_y} * `SPRITE_FB_WIDTH + {16'b0, pix.screen_x};
    assign fb_addr    = `SPRITE_FB_BASE + (fb_index << 1);
    assign pix_ready  = (state == W_IDLE);
    assign aw_done    = !awvalid || awready;
    assign w_done     = !wvalid || wready;
    assign frame_done = bvalid && bready && last_q; // final response of the blit

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= W_IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            case (state)
                W_IDLE: if (pix_valid) begin
                    awaddr  <= fb_addr;
                    wdata   <= {pix.color, pix.color}; // both lanes, strobe picks one
                    wstrb   <= fb_addr[1] ? 4'b1100 : 4'b0011;
                    last_q  <= pix.last;
                    awvalid <= 1'b1;
                    wvalid  <= 1'b1;
                    state   <= W_SEND;
                end
                W_SEND: begin
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    if (aw_done && w_done) begin
                        bready <= 1'b1;
                        state  <= W_RESP;
                    end
                end
                W_RESP: if (bvalid) begin
                    bready <= 1'b0;
                    state  <= W_IDLE;
                end
                default: state <= W_IDLE;
            endcase
        end
    end

endmodule

// ==== src/sprite_blit_top.sv ====
`timescale 1ns/1ps
`include "sprite_consts.svh"

module sprite_blit_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cmd_valid,
    output logic                      cmd_ready,
    input  sprite_pkg::blit_cmd_t     cmd,
    output logic                      arvalid,
    input  logic                      arready,
    output logic [`SPRITE_ADDR_W-1:0] araddr,
    input  logic                      rvalid,
    output logic                      rready,
    input  logic [`SPRITE_ADDR_W-1:0] rdata,
    output logic                      awvalid,
    input  logic                      awready,
    output logic [`SPRITE_ADDR_W-1:0] awaddr,
    output logic                      wvalid,
    input  logic                      wready,
    output logic [`SPRITE_ADDR_W-1:0] wdata,
    output logic [3:0]                wstrb,
    input  logic                      bvalid,
    output logic                      bready
);

    sprite_pkg::blit_cmd_t  cmd_q;
    sprite_pkg::frag_t      frag;
    sprite_pkg::fetch_req_t req;
    sprite_pkg::pixel_t     pix;
    logic frag_valid, frag_ready;
    logic req_valid, req_ready;
    logic pix_valid, pix_ready;
    logic frame_done;

    sprite_coord_gen coord_i (
        .clk, .rst, .cmd_valid, .cmd_ready, .cmd, .frame_done,
        .frag_valid, .frag_ready, .frag, .cmd_q
    );

    sprite_addr_calc addr_i (
        .clk, .rst, .cmd_q, .frag_valid, .frag_ready, .frag,
        .req_valid, .req_ready, .req
    );

    sprite_pixel_fetch fetch_i (
        .clk, .rst, .req_valid, .req_ready, .req,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata,
        .pix_valid, .pix_ready, .pix
    );

    sprite_pixel_write write_i (
        .clk, .rst, .pix_valid, .pix_ready, .pix,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .frame_done
    );

endmodule

// ==== test/sprite_blit_properties.sv ====
`timescale 1ns/1ps
`include "sprite_consts.svh"

module sprite_blit_properties (
    input logic                      clk,
    input logic                      rst,
    input logic                      cmd_ready,
    input logic                      arvalid,
    input logic                      arready,
    input logic [`SPRITE_ADDR_W-1:0] araddr,
    input logic                      awvalid,
    input logic                      awready,
    input logic                      wvalid,
    input logic                      wready
);

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid or araddr changed before arready");

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid)
        else $error("wvalid dropped before wready");

    // first reset edge has no defined history
    quiet_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> !cmd_ready && !arvalid)
        else $error("cmd_ready or arvalid high during reset");

endmodule

bind sprite_blit_top sprite_blit_properties props_i (
    .clk       (clk),
    .rst       (rst),
    .cmd_ready (cmd_ready),
    .arvalid   (arvalid),
    .arready   (arready),
    .araddr    (araddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wvalid    (wvalid),
    .wready    (wready)
);

// ==== test/sprite_blit_tb.sv ====
`timescale 1ns/1ps
`include "sprite_consts.svh"

module sprite_blit_tb;

    localparam int FB_PIX = `SPRITE_FB_WIDTH * 32;
    localparam int SHEET_WORDS = 1024;

    logic                  clk;
    logic                  rst;
    logic                  cmd_valid;
    logic                  cmd_ready;
    sprite_pkg::blit_cmd_t cmd;
    logic                  arvalid, arready, rvalid, rready;
    logic [31:0]           araddr, rdata;
    logic                  awvalid, awready, wvalid, wready, bvalid, bready;
    logic [31:0]           awaddr, wdata;
    logic [3:0]            wstrb;

    logic [31:0] sheet_mem [0:SHEET_WORDS-1];
    logic [15:0] fb [0:FB_PIX-1];
    logic [15:0] fb_before [0:FB_PIX-1];
    logic [15:0] fb_snap [0:FB_PIX-1];
    logic [15:0] exp_fb [0:FB_PIX-1];
    logic        touched [0:FB_PIX-1];
    int          wr_count [0:FB_PIX-1];
    logic [31:0] lfsr;
    logic        bp;
    int          ar_count, b_count;
    logic [31:0] prev_word;
    logic        prev_ok;

    sprite_blit_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = b ? ((lfsr >> 1) ^ 32'ha300_0001) : (lfsr >> 1); // galois taps
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) v = {v[30:0], next_bit()};
        return v;
    endfunction

    function automatic logic coin();
        return bp ? next_bit() : 1'b1;
    endfunction

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
            abort($sformatf("ERR %0t: %s got %0h expected %0h", $time, what, got, exp));
    endtask

    function automatic int scale_mag(input logic signed [15:0] s);
        int m;
        m = (s < 0) ? -int'(s) : int'(s);
        return (m == 0) ? 1 : m;
    endfunction

    // byte address of the sheet pixel behind screen offset (i,j)
    function automatic logic [31:0] sheet_addr(input sprite_pkg::blit_cmd_t c, input int i,
                                               input int j);
        int sx, sy;
        sx = (c.scale_x < 0) ? c.src_x + i * scale_mag(c.scale_x)
                             : c.src_x + i / scale_mag(c.scale_x);
        sy = (c.scale_y < 0) ? c.src_y + j * scale_mag(c.scale_y)
                             : c.src_y + j / scale_mag(c.scale_y);
        return c.sheet_base + 2 * (sy * c.sheet_width + sx);
    endfunction

    function automatic sprite_pkg::pixel_t expected_pixel(input sprite_pkg::blit_cmd_t c,
                                                          input int i, input int j);
        sprite_pkg::pixel_t p;
        logic [31:0]        a;
        logic [31:0]        w;
        a = sheet_addr(c, i, j);
        w = sheet_mem[(a >> 2) % SHEET_WORDS];
        p.color    = a[1] ? w[31:16] : w[15:0];
        p.screen_x = c.mirror_x ? c.dst_x + c.width - 1 - i : c.dst_x + i;
        p.screen_y = c.mirror_y ? c.dst_y + c.height - 1 - j : c.dst_y + j;
        p.last     = (i == c.width - 1) && (j == c.height - 1);
        return p;
    endfunction

    // read slave
    initial begin
        logic        ar_hs, r_hs, pend;
        logic [31:0] addr_q;
        pend = 1'b0;
        forever begin
            @(posedge clk);
            ar_hs = arvalid && arready;
            r_hs  = rvalid && rready;
            if (ar_hs) begin
                check_eq(araddr[1:0], 2'b00, "araddr alignment");
                addr_q = araddr;
                ar_count++;
            end
            #1;
            if (rst) begin
                arready = 1'b0;
                rvalid  = 1'b0;
                pend    = 1'b0;
            end else begin
                if (ar_hs) pend = 1'b1;
                if (r_hs) rvalid = 1'b0;
                if (pend && !rvalid && coin()) begin
                    if ((addr_q >> 2) >= SHEET_WORDS) abort("read outside the sprite sheet");
                    rdata  = sheet_mem[addr_q >> 2];
                    rvalid = 1'b1;
                    pend   = 1'b0;
                end
                arready = !pend && !rvalid && coin();
            end
        end
    end

    // write slave
    initial begin
        logic        aw_hs, w_hs, b_hs, aw_got, w_got;
        logic [31:0] aw_q, wd_q, idx;
        logic [3:0]  ws_q;
        aw_got = 1'b0;
        w_got  = 1'b0;
        forever begin
            @(posedge clk);
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            b_hs  = bvalid && bready;
            if (aw_hs) aw_q = awaddr;
            if (w_hs) begin
                wd_q = wdata;
                ws_q = wstrb;
            end
            if (b_hs) b_count++;
            #1;
            if (rst) begin
                awready = 1'b0;
                wready  = 1'b0;
                bvalid  = 1'b0;
                aw_got  = 1'b0;
                w_got   = 1'b0;
            end else begin
                aw_got = aw_got || aw_hs;
                w_got  = w_got || w_hs;
                if (b_hs) bvalid = 1'b0;
                if (aw_got && w_got && !bvalid && coin()) begin
                    idx = (aw_q - `SPRITE_FB_BASE) >> 1;
                    if (aw_q < `SPRITE_FB_BASE || idx >= FB_PIX)
                        abort("write outside the framebuffer");
                    check_eq(ws_q, aw_q[1] ? 4'b1100 : 4'b0011, "wstrb");
                    check_eq(wd_q[31:16], wd_q[15:0], "wdata halves");
                    fb[idx] = aw_q[1] ? wd_q[31:16] : wd_q[15:0];
                    wr_count[idx]++;
                    bvalid = 1'b1;
                    aw_got = 1'b0;
                    w_got  = 1'b0;
                end
                awready = !aw_got && coin();
                wready  = !w_got && coin();
            end
        end
    end

    function automatic sprite_pkg::blit_cmd_t make_cmd(input int sx, input int sy, input int dx,
                                                       input int dy, input int w, input int h,
                                                       input int scx, input int scy,
                                                       input logic mx, input logic my);
        sprite_pkg::blit_cmd_t c;
        c.sheet_base  = 32'h0000_0100;
        c.sheet_width = 16'd40;
        c.src_x       = sx;
        c.src_y       = sy;
        c.dst_x       = dx;
        c.dst_y       = dy;
        c.width       = w;
        c.height      = h;
        c.scale_x     = scx;
        c.scale_y     = scy;
        c.mirror_x    = mx;
        c.mirror_y    = my;
        return c;
    endfunction

    task automatic check_frame(input sprite_pkg::blit_cmd_t c);
        sprite_pkg::pixel_t p;
        int                 idx;
        for (int k = 0; k < FB_PIX; k++) begin
            exp_fb[k]  = fb_before[k];
            touched[k] = 1'b0;
        end
        for (int j = 0; j < c.height; j++) begin
            for (int i = 0; i < c.width; i++) begin
                p = expected_pixel(c, i, j);
                idx = p.screen_y * `SPRITE_FB_WIDTH + p.screen_x;
                exp_fb[idx]  = p.color;
                touched[idx] = 1'b1;
            end
        end
        for (int k = 0; k < FB_PIX; k++) begin
            check_eq(fb[k], exp_fb[k], $sformatf("framebuffer pixel %0d", k));
            check_eq(wr_count[k], touched[k] ? 1 : 0, $sformatf("write count of pixel %0d", k));
        end
    endtask

    task automatic run_blit(input sprite_pkg::blit_cmd_t c, input logic bp_on);
        int          n;
        int          exp_ar;
        logic [31:0] w;
        exp_ar = 0;
        for (int j = 0; j < c.height; j++) begin
            for (int i = 0; i < c.width; i++) begin
                w = sheet_addr(c, i, j) >> 2;
                if (!prev_ok || w != prev_word) exp_ar++; // cache keeps the last word
                prev_word = w;
                prev_ok   = 1'b1;
            end
        end
        for (int k = 0; k < FB_PIX; k++) begin
            fb_before[k] = fb[k];
            wr_count[k]  = 0;
        end
        bp       = bp_on;
        ar_count = 0;
        b_count  = 0;
        #1;
        cmd       = c;
        cmd_valid = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > 100) abort("the command was never accepted");
        end while (!cmd_ready);
        #1;
        cmd_valid = 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > 50000) abort("the blit never finished");
        end while (!cmd_ready);
        check_eq(b_count, c.width * c.height, "write responses before cmd_ready");
        check_eq(ar_count, exp_ar, "AR handshakes");
        check_frame(c);
    endtask

    initial begin
        int n;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        arready   = 1'b0;
        rvalid    = 1'b0;
        rdata     = '0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        bp        = 1'b0;
        prev_ok   = 1'b0;
        prev_word = '0;
        ar_count  = 0;
        b_count   = 0;
        lfsr      = 32'h6317fc72;
        for (int k = 0; k < SHEET_WORDS; k++) sheet_mem[k] = rand_bits(32) ^ {k[15:0], ~k[15:0]};
        for (int k = 0; k < FB_PIX; k++) fb[k] = k[15:0] ^ 16'ha5c3;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > 20) abort("cmd_ready did not rise after reset");
        end while (!cmd_ready);
        check_eq({arvalid, rready, awvalid, wvalid, bready}, 5'b0, "bus outputs after reset");

        run_blit(make_cmd(3, 2, 5, 4, 7, 3, 1, 1, 1'b0, 1'b0), 1'b0);
        for (int k = 0; k < FB_PIX; k++) fb_snap[k] = fb[k];
        run_blit(make_cmd(10, 5, 20, 8, 9, 4, 3, 2, 1'b1, 1'b0), 1'b0);
        run_blit(make_cmd(1, 6, 40, 2, 5, 4, -2, -2, 1'b0, 1'b1), 1'b0);
        run_blit(make_cmd(0, 20, 2, 20, 6, 2, 0, 0, 1'b0, 1'b0), 1'b0);

        // restore the fill, then repeat the first copy under back-pressure
        for (int k = 0; k < FB_PIX; k++) fb[k] = k[15:0] ^ 16'ha5c3;
        run_blit(make_cmd(3, 2, 5, 4, 7, 3, 1, 1, 1'b0, 1'b0), 1'b1);
        for (int k = 0; k < FB_PIX; k++)
            check_eq(fb[k], fb_snap[k], $sformatf("back-pressure copy pixel %0d", k));

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+src
src/sprite_pkg.sv
src/pipe_skid.sv
src/sprite_coord_gen.sv
src/sprite_addr_calc.sv
src/sprite_pixel_fetch.sv
src/sprite_pixel_write.sv
src/sprite_blit_top.sv
test/sprite_blit_properties.sv
test/sprite_blit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module sprite_blit_tb -f verilog.f -o sim_sprite_blit

./obj_dir/sim_sprite_blit | tee sim.log

grep -q "Testbench passed" sim.log
